//--- verilog/wb_map_pkg.sv
// Control slave bus widths, register map and reset values
package wb_map_pkg;

   ////////////////////////////////////////////////////////////////////
   // Bus geometry

   localparam int WB_DW     = 16;   // Data width
   localparam int WB_AW     = 11;   // Address width
   localparam int REG_OFS_W = 7;    // Decoded low address bits

   typedef logic [REG_OFS_W-1:0] reg_ofs_t;

   ////////////////////////////////////////////////////////////////////
   // Register byte offsets

   localparam reg_ofs_t REG_LEDS         = 7'd0;    // rw
   localparam reg_ofs_t REG_SWITCHES     = 7'd2;    // ro, buttons and DIP
   localparam reg_ofs_t REG_TEST         = 7'd4;    // rw scratch
   localparam reg_ofs_t REG_XFER_RATE    = 7'd6;    // rw, enables and divider
   localparam reg_ofs_t REG_UNDERRUN_CNT = 7'd8;    // ro
   localparam reg_ofs_t REG_OVERRUN_CNT  = 7'd10;   // ro
   localparam reg_ofs_t REG_STATUS       = 7'd12;   // ro flags, write clears

   // Returned for any offset not in the map
   localparam logic [WB_DW-1:0] UNMAPPED_VALUE = 16'hBEEF;

   ////////////////////////////////////////////////////////////////////
   // Reset values

   localparam logic [WB_DW-1:0] LEDS_RST      = '0;
   localparam logic [WB_DW-1:0] TEST_RST      = '0;
   localparam logic [WB_DW-1:0] XFER_RATE_RST = '0;   // Both paths disabled

endpackage

//--- verilog/xfer_pkg.sv
// Stream payload types and pacing constants for the TX and RX paths
package xfer_pkg;

   ////////////////////////////////////////////////////////////////////
   // Pacing and accounting widths

   localparam int RATE_W = 8;    // Slot divider width
   localparam int CNT_W  = 16;   // Event counter width

   // Bit positions inside the transfer-rate register
   localparam int XFER_TX_EN_BIT = 15;
   localparam int XFER_RX_EN_BIT = 14;
   // Rate field sits in the low RATE_W bits

   ////////////////////////////////////////////////////////////////////
   // Payloads

   localparam int FRAME_DW = 32;   // Host data bits per word
   localparam int OCC_W    = 2;    // Valid byte occupancy
   localparam int IQ_W     = 16;   // One sample component

   // Host frame word, 34 bits
   typedef struct packed {
      logic [OCC_W-1:0]    occ;    // Bytes in use on the last word
      logic [FRAME_DW-1:0] data;
   } frame_word_t;

   // Radio sample, 32 bits
   typedef struct packed {
      logic [IQ_W-1:0] i;
      logic [IQ_W-1:0] q;
   } sample_t;

endpackage

//--- verilog/xfer_ifs.sv
// Ready/ready stream interface and pacer status interface
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////
// Stream of one payload type, word moves when src_rdy and dst_rdy
// are both high on a rising edge

interface stream_if #(
   parameter type payload_t = logic
);

   payload_t data;
   logic     sof;       // First word of a frame
   logic     eof;       // Last word of a frame
   logic     src_rdy;   // Producer has a word
   logic     dst_rdy;   // Consumer takes a word

   // Producer side
   modport src (
      output data,
      output sof,
      output eof,
      output src_rdy,
      input  dst_rdy
   );

   // Consumer side
   modport dst (
      input  data,
      input  sof,
      input  eof,
      input  src_rdy,
      output dst_rdy
   );

endinterface

////////////////////////////////////////////////////////////////////////
// Underrun and overrun results from the status block

interface status_if import xfer_pkg::*; ();

   logic [CNT_W-1:0] underrun_cnt;
   logic [CNT_W-1:0] overrun_cnt;
   logic             underrun_flag;   // Sticky
   logic             overrun_flag;    // Sticky
   logic             clear;           // One cycle, from the register block

   modport prod (
      output underrun_cnt,
      output overrun_cnt,
      output underrun_flag,
      output overrun_flag,
      input  clear
   );

   modport cons (
      input  underrun_cnt,
      input  overrun_cnt,
      input  underrun_flag,
      input  overrun_flag,
      output clear
   );

endinterface

//--- verilog/fifo_pacer.sv
// Releases one stream word per rate+1 cycles and flags missed slots
`timescale 1ns/1ps

module fifo_pacer #(
   parameter type payload_t = logic,
   parameter int  RATE_W    = 8
) (
   input  logic              wb_clk,
   input  logic              wb_rst,

   input  logic [RATE_W-1:0] rate_i,     // Slot period minus one
   input  logic              enable_i,

   stream_if.dst             up_s,       // From the producer
   stream_if.src             down_s,     // To the consumer

   output logic              underrun_o, // Slot with nothing to send
   output logic              overrun_o   // Slot blocked by consumer
);

   logic [RATE_W-1:0] slot_cnt;
   logic              slot;
   payload_t          word;

   ////////////////////////////////////////////////////////////////////
   // Slot counter

   // Wraps at the rate, held at zero while disabled
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst || !enable_i)
      begin
         slot_cnt <= '0;
      end
      else if (slot_cnt >= rate_i)   // Also recovers if rate drops
      begin
         slot_cnt <= '0;
      end
      else
      begin
         slot_cnt <= slot_cnt + 1'b1;
      end
   end

   assign slot = enable_i && (slot_cnt >= rate_i);

   ////////////////////////////////////////////////////////////////////
   // Strobe gating

   // Payload passes straight through, only the strobes are paced
   assign word        = up_s.data;
   assign down_s.data = word;
   assign down_s.sof  = up_s.sof;
   assign down_s.eof  = up_s.eof;

   assign down_s.src_rdy = slot & up_s.src_rdy;
   assign up_s.dst_rdy   = slot & down_s.dst_rdy;

   // A blocked slot is simply lost
   assign underrun_o = slot & ~up_s.src_rdy;
   assign overrun_o  = slot & ~down_s.dst_rdy;

endmodule

//--- verilog/xfer_status.sv
// Sticky flags and saturating counters for pacer underrun and overrun
`timescale 1ns/1ps

module xfer_status import xfer_pkg::*; (
   input  logic wb_clk,
   input  logic wb_rst,

   input  logic tx_underrun_i,   // From the TX pacer
   input  logic rx_overrun_i,    // From the RX pacer

   status_if.prod st
);

   logic [CNT_W-1:0] underrun_cnt;
   logic [CNT_W-1:0] overrun_cnt;
   logic             underrun_flag;
   logic             overrun_flag;

   // Clear takes priority over an event in the same cycle
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst || st.clear)
      begin
         underrun_cnt  <= '0;
         overrun_cnt   <= '0;
         underrun_flag <= 1'b0;
         overrun_flag  <= 1'b0;
      end
      else
      begin
         if (tx_underrun_i)
         begin
            underrun_flag <= 1'b1;
            if (underrun_cnt != '1)   // Saturate
               underrun_cnt <= underrun_cnt + 1'b1;
         end
         if (rx_overrun_i)
         begin
            overrun_flag <= 1'b1;
            if (overrun_cnt != '1)
               overrun_cnt <= overrun_cnt + 1'b1;
         end
      end
   end

   assign st.underrun_cnt  = underrun_cnt;
   assign st.overrun_cnt   = overrun_cnt;
   assign st.underrun_flag = underrun_flag;
   assign st.overrun_flag  = overrun_flag;

endmodule

//--- verilog/wb_regs.sv
// Wishbone control slave for LEDs, switches, test, rate and pacer status
`timescale 1ns/1ps

module wb_regs import wb_map_pkg::*, xfer_pkg::*; #(
   parameter int RATE_W = xfer_pkg::RATE_W
) (
   input  logic              wb_clk,
   input  logic              wb_rst,

   input  logic [WB_AW-1:0]  wb_adr_i,
   input  logic [WB_DW-1:0]  wb_dat_i,
   output logic [WB_DW-1:0]  wb_dat_o,
   input  logic              wb_we_i,
   input  logic              wb_stb_i,
   input  logic              wb_cyc_i,
   output logic              wb_ack_o,

   input  logic [7:0]        dip_sw_i,
   input  logic [2:0]        debug_pb_i,
   output logic [2:0]        debug_led_o,

   output logic              tx_enable_o,
   output logic              rx_enable_o,
   output logic [RATE_W-1:0] rate_o,

   status_if.cons            st
);

   logic [WB_DW-1:0] reg_leds;
   logic [WB_DW-1:0] reg_test;
   logic [WB_DW-1:0] reg_xfer_rate;
   reg_ofs_t         ofs;
   logic             wr_en;

   assign ofs      = wb_adr_i[REG_OFS_W-1:0];
   assign wb_ack_o = wb_stb_i & wb_cyc_i;   // Zero wait states
   assign wr_en    = wb_ack_o & wb_we_i;

   ////////////////////////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= LEDS_RST;
         reg_test      <= TEST_RST;
         reg_xfer_rate <= XFER_RATE_RST;
      end
      else if (wr_en)
      begin
         case (ofs)
            REG_LEDS      : reg_leds      <= wb_dat_i;
            REG_TEST      : reg_test      <= wb_dat_i;
            REG_XFER_RATE : reg_xfer_rate <= wb_dat_i;
            default       : ;                       // Read-only or unmapped
         endcase
      end
   end

   // Status write only clears, data is ignored
   assign st.clear = wr_en && (ofs == REG_STATUS);

   ////////////////////////////////////////////////////////////////////
   // Decoded controls

   assign tx_enable_o = reg_xfer_rate[XFER_TX_EN_BIT];
   assign rx_enable_o = reg_xfer_rate[XFER_RX_EN_BIT];
   assign rate_o      = reg_xfer_rate[RATE_W-1:0];

   // LEDs are not in bit order on the board
   assign debug_led_o = {reg_leds[2], reg_leds[0], reg_leds[1]};

   ////////////////////////////////////////////////////////////////////
   // Readback

   always_comb
   begin
      case (ofs)
         REG_LEDS         : wb_dat_o = reg_leds;
         REG_SWITCHES     : wb_dat_o = {{(WB_DW-11){1'b0}}, debug_pb_i, dip_sw_i};
         REG_TEST         : wb_dat_o = reg_test;
         REG_XFER_RATE    : wb_dat_o = reg_xfer_rate;
         REG_UNDERRUN_CNT : wb_dat_o = st.underrun_cnt;
         REG_OVERRUN_CNT  : wb_dat_o = st.overrun_cnt;
         REG_STATUS       :
         begin
            // Underrun in bit 0, overrun in bit 1
            wb_dat_o = {{(WB_DW-2){1'b0}}, st.overrun_flag, st.underrun_flag};
         end
         default          : wb_dat_o = UNMAPPED_VALUE;
      endcase
   end

endmodule

//--- verilog/u1e_xfer_top.sv
// Paced TX and RX streaming core with its Wishbone control slave
`timescale 1ns/1ps

module u1e_xfer_top import wb_map_pkg::*, xfer_pkg::*; #(
   parameter int RATE_W = xfer_pkg::RATE_W
) (
   input  logic             wb_clk,
   input  logic             wb_rst,

   // Wishbone slave
   input  logic [WB_AW-1:0] wb_adr_i,
   input  logic [WB_DW-1:0] wb_dat_i,
   input  logic             wb_we_i,
   input  logic             wb_stb_i,
   input  logic             wb_cyc_i,
   output logic [WB_DW-1:0] wb_dat_o,
   output logic             wb_ack_o,

   // Board
   input  logic [7:0]       dip_sw_i,
   input  logic [2:0]       debug_pb_i,
   output logic [2:0]       debug_led_o,

   // TX host side
   input  frame_word_t      tx_in_data_i,
   input  logic             tx_in_sof_i,
   input  logic             tx_in_eof_i,
   input  logic             tx_in_src_rdy_i,
   output logic             tx_in_dst_rdy_o,

   // TX radio side
   output frame_word_t      tx_out_data_o,
   output logic             tx_out_sof_o,
   output logic             tx_out_eof_o,
   output logic             tx_out_src_rdy_o,
   input  logic             tx_out_dst_rdy_i,

   // RX radio side
   input  sample_t          rx_in_data_i,
   input  logic             rx_in_sof_i,
   input  logic             rx_in_eof_i,
   input  logic             rx_in_src_rdy_i,
   output logic             rx_in_dst_rdy_o,

   // RX host side
   output sample_t          rx_out_data_o,
   output logic             rx_out_sof_o,
   output logic             rx_out_eof_o,
   output logic             rx_out_src_rdy_o,
   input  logic             rx_out_dst_rdy_i,

   output logic             tx_underrun_o,   // Sticky, cleared by status write
   output logic             rx_overrun_o
);

   logic              tx_enable;
   logic              rx_enable;
   logic [RATE_W-1:0] rate;
   logic              tx_underrun;
   logic              rx_overrun;

   stream_if #(.payload_t(frame_word_t)) tx_up_s ();
   stream_if #(.payload_t(frame_word_t)) tx_down_s ();
   stream_if #(.payload_t(sample_t))     rx_up_s ();
   stream_if #(.payload_t(sample_t))     rx_down_s ();
   status_if                             st ();

   ////////////////////////////////////////////////////////////////////
   // Control and status

   wb_regs #(.RATE_W(RATE_W)) regs (
      .wb_clk, .wb_rst,
      .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_we_i, .wb_stb_i, .wb_cyc_i, .wb_ack_o,
      .dip_sw_i, .debug_pb_i, .debug_led_o,
      .tx_enable_o (tx_enable),
      .rx_enable_o (rx_enable),
      .rate_o      (rate),
      .st          (st.cons)
   );

   xfer_status status (
      .wb_clk, .wb_rst,
      .tx_underrun_i (tx_underrun),
      .rx_overrun_i  (rx_overrun),
      .st            (st.prod)
   );

   assign tx_underrun_o = st.underrun_flag;
   assign rx_overrun_o  = st.overrun_flag;

   ////////////////////////////////////////////////////////////////////
   // TX path, host to radio

   assign tx_up_s.data     = tx_in_data_i;
   assign tx_up_s.sof      = tx_in_sof_i;
   assign tx_up_s.eof      = tx_in_eof_i;
   assign tx_up_s.src_rdy  = tx_in_src_rdy_i;
   assign tx_in_dst_rdy_o  = tx_up_s.dst_rdy;

   fifo_pacer #(.payload_t(frame_word_t), .RATE_W(RATE_W)) tx_pacer (
      .wb_clk, .wb_rst,
      .rate_i     (rate),
      .enable_i   (tx_enable),
      .up_s       (tx_up_s.dst),
      .down_s     (tx_down_s.src),
      .underrun_o (tx_underrun),
      .overrun_o  ()                 // Radio side never stalls the count
   );

   assign tx_out_data_o     = tx_down_s.data;
   assign tx_out_sof_o      = tx_down_s.sof;
   assign tx_out_eof_o      = tx_down_s.eof;
   assign tx_out_src_rdy_o  = tx_down_s.src_rdy;
   assign tx_down_s.dst_rdy = tx_out_dst_rdy_i;

   ////////////////////////////////////////////////////////////////////
   // RX path, radio to host

   assign rx_up_s.data     = rx_in_data_i;
   assign rx_up_s.sof      = rx_in_sof_i;
   assign rx_up_s.eof      = rx_in_eof_i;
   assign rx_up_s.src_rdy  = rx_in_src_rdy_i;
   assign rx_in_dst_rdy_o  = rx_up_s.dst_rdy;

   fifo_pacer #(.payload_t(sample_t), .RATE_W(RATE_W)) rx_pacer (
      .wb_clk, .wb_rst,
      .rate_i     (rate),
      .enable_i   (rx_enable),
      .up_s       (rx_up_s.dst),
      .down_s     (rx_down_s.src),
      .underrun_o (),
      .overrun_o  (rx_overrun)
   );

   assign rx_out_data_o     = rx_down_s.data;
   assign rx_out_sof_o      = rx_down_s.sof;
   assign rx_out_eof_o      = rx_down_s.eof;
   assign rx_out_src_rdy_o  = rx_down_s.src_rdy;
   assign rx_down_s.dst_rdy = rx_out_dst_rdy_i;

endmodule

//--- include/tb_tasks.svh
// Testbench tasks for bus access, paced stream traffic and value checks
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////////////////////////////////////
// Checks and bookkeeping

task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
   begin
      assert (act === exp)
      else
      begin
         $display("CHECK FAILED %s: expected %0h actual %0h", name, exp, act);
         errors++;
      end
   end
endtask

task automatic test_done(input string name);
   begin
      tests++;
      $display("Test %s finished, %0d errors so far", name, errors);
   end
endtask

////////////////////////////////////////////////////////////////////////
// Wishbone access, one cycle with stb and cyc high

task automatic bus_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
   begin
      @(negedge wb_clk);
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_we_i  = 1'b1;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      @(negedge wb_clk);   // Committed at the rising edge in between
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
   end
endtask

task automatic bus_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
   begin
      @(negedge wb_clk);
      wb_adr_i = adr;
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      #1;
      dat = wb_dat_o;   // Readback is combinational
      @(negedge wb_clk);
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
   end
endtask

task automatic read_check(input string name, input logic [WB_AW-1:0] adr,
                          input logic [WB_DW-1:0] exp);
   logic [WB_DW-1:0] dat;
   begin
      bus_read(adr, dat);
      check_val(name, 64'(exp), 64'(dat));
   end
endtask

////////////////////////////////////////////////////////////////////////
// Waits

// Waits for the sticky underrun or overrun output
task automatic wait_flag(input bit rx_side, input int limit);
   int cnt;
   begin
      cnt = 0;
      do
      begin
         @(negedge wb_clk);
         cnt++;
      end while (!(rx_side ? rx_overrun_o : tx_underrun_o) && cnt < limit);
      if (!(rx_side ? rx_overrun_o : tx_underrun_o))
      begin
         $display("Timed out waiting for the %s flag", rx_side ? "overrun" : "underrun");
         errors++;
      end
   end
endtask

`endif

//--- dv/tb_u1e_xfer.sv
// Testbench for the paced streaming core and its control slave
`timescale 1ns/1ps

module tb_u1e_xfer import wb_map_pkg::*, xfer_pkg::*; ();

   logic             wb_clk = 1'b0;
   logic             wb_rst;
   logic [WB_AW-1:0] wb_adr_i;
   logic [WB_DW-1:0] wb_dat_i, wb_dat_o;
   logic             wb_we_i, wb_stb_i, wb_cyc_i, wb_ack_o;
   logic [7:0]       dip_sw_i;
   logic [2:0]       debug_pb_i, debug_led_o;
   frame_word_t      tx_in_data_i, tx_out_data_o;
   logic             tx_in_sof_i, tx_in_eof_i, tx_in_src_rdy_i, tx_in_dst_rdy_o;
   logic             tx_out_sof_o, tx_out_eof_o, tx_out_src_rdy_o, tx_out_dst_rdy_i;
   sample_t          rx_in_data_i, rx_out_data_o;
   logic             rx_in_sof_i, rx_in_eof_i, rx_in_src_rdy_i, rx_in_dst_rdy_o;
   logic             rx_out_sof_o, rx_out_eof_o, rx_out_src_rdy_o, rx_out_dst_rdy_i;
   logic             tx_underrun_o, rx_overrun_o;

   int               errors = 0;
   int               tests  = 0;
   integer           seed   = 32'h732b;
   logic             hold_on = 1'b0;   // Both paths disabled
   logic [31:0]      r;

   always #5 wb_clk = ~wb_clk;

   u1e_xfer_top #(.RATE_W(RATE_W)) uut (.*);

   `include "tb_tasks.svh"

   ////////////////////////////////////////////////////////////////////
   // Concurrent checks

   assert property (@(posedge wb_clk) wb_ack_o == (wb_stb_i && wb_cyc_i))
   else
   begin
      $display("CHECK FAILED ack: expected %b actual %b", wb_stb_i && wb_cyc_i, wb_ack_o);
      errors++;
   end

   assert property (@(posedge wb_clk) disable iff (wb_rst)
      hold_on |-> !(tx_out_src_rdy_o || tx_in_dst_rdy_o || rx_out_src_rdy_o || rx_in_dst_rdy_o))
   else
   begin
      $display("A stream strobe went high while both paths were disabled");
      errors++;
   end

   ////////////////////////////////////////////////////////////////////
   // Paced transfers with source and sink always ready

   task automatic pace_tx(input int rate, input int n);
      int          idx, cyc, last;
      frame_word_t w;
      begin
         idx  = 0;
         cyc  = 0;
         last = -1;
         r = $random(seed);
         w.data = $random(seed);
         w.occ  = r[1:0];
         tx_in_src_rdy_i  = 1'b1;
         tx_out_dst_rdy_i = 1'b1;
         while (idx < n && cyc < (n + 2) * (rate + 1))
         begin
            @(negedge wb_clk);
            tx_in_data_i = w;
            tx_in_sof_i  = (idx == 0);
            tx_in_eof_i  = (idx == n - 1);
            #1;
            if (tx_in_dst_rdy_o && tx_out_src_rdy_o)   // Word moves at next edge
            begin
               check_val("tx_data", 64'(w), 64'(tx_out_data_o));
               check_val("tx_sof", 64'(idx == 0), 64'(tx_out_sof_o));
               check_val("tx_eof", 64'(idx == n - 1), 64'(tx_out_eof_o));
               if (last >= 0)
                  check_val("tx_gap", 64'(rate + 1), 64'(cyc - last));
               last = cyc;
               idx++;
               r = $random(seed);
               w.data = $random(seed);
               w.occ  = r[1:0];
            end
            cyc++;
         end
         if (idx < n)
         begin
            $display("Timed out waiting for TX transfers, %0d of %0d seen", idx, n);
            errors++;
         end
         @(negedge wb_clk);
         tx_in_src_rdy_i = 1'b0;
      end
   endtask

   task automatic pace_rx(input int rate, input int n);
      int      idx, cyc, last;
      sample_t w;
      begin
         idx  = 0;
         cyc  = 0;
         last = -1;
         w = $random(seed);
         rx_in_src_rdy_i  = 1'b1;
         rx_out_dst_rdy_i = 1'b1;
         while (idx < n && cyc < (n + 2) * (rate + 1))
         begin
            @(negedge wb_clk);
            rx_in_data_i = w;
            rx_in_sof_i  = (idx == 0);
            rx_in_eof_i  = (idx == n - 1);
            #1;
            if (rx_in_dst_rdy_o && rx_out_src_rdy_o)
            begin
               check_val("rx_data", 64'(w), 64'(rx_out_data_o));
               check_val("rx_sof", 64'(idx == 0), 64'(rx_out_sof_o));
               check_val("rx_eof", 64'(idx == n - 1), 64'(rx_out_eof_o));
               if (last >= 0)
                  check_val("rx_gap", 64'(rate + 1), 64'(cyc - last));
               last = cyc;
               idx++;
               w = $random(seed);
            end
            cyc++;
         end
         if (idx < n)
         begin
            $display("Timed out waiting for RX transfers, %0d of %0d seen", idx, n);
            errors++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Stimulus

   initial
   begin
      wb_rst           = 1'b1;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      wb_we_i          = 1'b0;
      wb_stb_i         = 1'b0;
      wb_cyc_i         = 1'b0;
      dip_sw_i         = '0;
      debug_pb_i       = '0;
      tx_in_data_i     = '0;
      tx_in_sof_i      = 1'b0;
      tx_in_eof_i      = 1'b0;
      tx_in_src_rdy_i  = 1'b0;
      tx_out_dst_rdy_i = 1'b0;
      rx_in_data_i     = '0;
      rx_in_sof_i      = 1'b0;
      rx_in_eof_i      = 1'b0;
      rx_in_src_rdy_i  = 1'b0;
      rx_out_dst_rdy_i = 1'b0;
      repeat (3) @(negedge wb_clk);
      wb_rst = 1'b0;

      // Registers
      for (int a = 0; a <= 12; a += 2)
         read_check("reset_value", WB_AW'(a), '0);
      check_val("led_reset", '0, 64'(debug_led_o));
      bus_write(WB_AW'(REG_LEDS), 16'h5A01);
      read_check("leds", WB_AW'(REG_LEDS), 16'h5A01);
      check_val("led_bit0", 64'(3'b010), 64'(debug_led_o));   // Bit 0 lights the middle LED
      bus_write(WB_AW'(REG_LEDS), 16'h0002);
      check_val("led_bit1", 64'(3'b001), 64'(debug_led_o));
      bus_write(WB_AW'(REG_LEDS), 16'h0004);
      check_val("led_bit2", 64'(3'b100), 64'(debug_led_o));
      bus_write(WB_AW'(REG_TEST), 16'hA5C3);
      read_check("test", WB_AW'(REG_TEST), 16'hA5C3);

      // Strobe without cycle, then cycle without strobe, neither is acked
      @(negedge wb_clk);
      wb_adr_i = WB_AW'(REG_TEST);
      wb_dat_i = 16'h1234;
      wb_we_i  = 1'b1;
      wb_stb_i = 1'b1;
      @(negedge wb_clk);
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b1;
      @(negedge wb_clk);
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b0;
      read_check("test_no_ack", WB_AW'(REG_TEST), 16'hA5C3);

      bus_write(WB_AW'(REG_XFER_RATE), 16'h0037);
      read_check("xfer_rate", WB_AW'(REG_XFER_RATE), 16'h0037);
      bus_write(WB_AW'(REG_XFER_RATE), 16'h0000);
      r = $random(seed);
      dip_sw_i   = r[7:0];
      debug_pb_i = 3'b101;
      read_check("switches", WB_AW'(REG_SWITCHES), {5'b0, 3'b101, r[7:0]});
      read_check("unmapped", WB_AW'(14), 16'hBEEF);
      test_done("registers");

      // Disabled hold
      hold_on = 1'b1;
      repeat (20)
      begin
         @(negedge wb_clk);
         r = $random(seed);
         {tx_in_src_rdy_i, tx_out_dst_rdy_i, rx_in_src_rdy_i, rx_out_dst_rdy_i} = r[3:0];
         tx_in_data_i.data = $random(seed);
         rx_in_data_i = $random(seed);
      end
      @(negedge wb_clk);
      hold_on = 1'b0;
      read_check("hold_underrun_cnt", WB_AW'(REG_UNDERRUN_CNT), '0);
      read_check("hold_overrun_cnt", WB_AW'(REG_OVERRUN_CNT), '0);
      test_done("disabled_hold");

      // TX and RX pacing
      rx_in_src_rdy_i = 1'b0;
      bus_write(WB_AW'(REG_XFER_RATE), 16'h8003);
      pace_tx(3, 8);
      test_done("tx_pacing");
      bus_write(WB_AW'(REG_XFER_RATE), 16'h4005);
      pace_rx(5, 8);
      test_done("rx_pacing");

      // Underrun accounting, TX source idle
      @(negedge wb_clk);
      tx_in_src_rdy_i  = 1'b0;
      tx_out_dst_rdy_i = 1'b1;
      bus_write(WB_AW'(REG_XFER_RATE), 16'h8004);
      bus_write(WB_AW'(REG_STATUS), 16'h0000);
      wait_flag(1'b0, 40);
      read_check("underrun_first", WB_AW'(REG_UNDERRUN_CNT), 16'd1);
      repeat (3) @(negedge wb_clk);   // Next sample five cycles later
      read_check("underrun_step", WB_AW'(REG_UNDERRUN_CNT), 16'd2);
      read_check("underrun_status", WB_AW'(REG_STATUS), 16'h0001);
      test_done("underrun");

      // Overrun accounting, RX sink blocked
      rx_in_src_rdy_i  = 1'b1;
      rx_out_dst_rdy_i = 1'b0;
      bus_write(WB_AW'(REG_XFER_RATE), 16'h4004);
      wait_flag(1'b1, 40);
      read_check("overrun_first", WB_AW'(REG_OVERRUN_CNT), 16'd1);
      repeat (3) @(negedge wb_clk);
      read_check("overrun_step", WB_AW'(REG_OVERRUN_CNT), 16'd2);
      read_check("overrun_status", WB_AW'(REG_STATUS), 16'h0003);
      bus_write(WB_AW'(REG_XFER_RATE), 16'h0000);
      bus_write(WB_AW'(REG_STATUS), 16'h0000);
      read_check("cleared_underrun_cnt", WB_AW'(REG_UNDERRUN_CNT), '0);
      read_check("cleared_overrun_cnt", WB_AW'(REG_OVERRUN_CNT), '0);
      check_val("cleared_flags", '0, 64'({rx_overrun_o, tx_underrun_o}));
      test_done("overrun_and_clear");

      $display("Tests run %0d, checks failed %0d", tests, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // Watchdog for the whole run
   initial
   begin
      #200us;
      $display("Simulation did not finish in time");
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- tb.f
+incdir+include
verilog/wb_map_pkg.sv
verilog/xfer_pkg.sv
verilog/xfer_ifs.sv
verilog/fifo_pacer.sv
verilog/xfer_status.sv
verilog/wb_regs.sv
verilog/u1e_xfer_top.sv
dv/tb_u1e_xfer.sv

//--- Makefile
# Verilator build for the paced streaming core testbench

VERILATOR ?= verilator
TOP       ?= tb_u1e_xfer
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') include/tb_tasks.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
